/* compile.f */
hw/adc_pkg.sv
hw/health_pkg.sv
hw/adc_sample_router.sv
hw/channel_level_checker.sv
hw/health_aggregator.sv
hw/monitor_top.sv
+incdir+verif
verif/monitor_tb.sv

/* hw/adc_pkg.sv */
// describes the conversion results delivered by the ADC sequencer.
package adc_pkg;

  // number of supply rails that are level checked.
  localparam int NUM_CHANNELS = 8;

  // width of one conversion result.
  localparam int ADC_RESULT_W = 12;

  // the sequencer channel field is wider than the checked set, so channel numbers
  // 8 to 31 can show up on the sample stream and must be ignored.
  localparam int CHANNEL_W = 5;

  // one conversion value.
  typedef logic [ADC_RESULT_W-1:0] adc_result_t;

  // channel number as carried by the sample stream.
  typedef logic [CHANNEL_W-1:0] adc_channel_t;

  // one bit per checked channel.
  typedef logic [NUM_CHANNELS-1:0] channel_mask_t;

endpackage

/* hw/adc_sample_router.sv */
module adc_sample_router
  import adc_pkg::*, health_pkg::*;
(
  input  logic          gclk40,
  input  logic          hard_reset,
  input  logic          sample_stb_i,
  input  adc_channel_t  sample_channel_i,
  input  adc_result_t   sample_result_i,
  input  logic          cfg_stb_i,
  input  adc_channel_t  cfg_channel_i,
  input  thresh_sel_t   cfg_sel_i,
  input  threshold_t    cfg_value_i,
  output channel_mask_t chan_sample_stb_o,
  output adc_result_t   sample_result_o,
  output channel_mask_t chan_cfg_stb_o,
  output thresh_sel_t   cfg_sel_o,
  output threshold_t    cfg_value_o
);

  // input capture stage.
  logic         sample_stb_q;
  adc_channel_t sample_channel_q;
  adc_result_t  sample_result_q;
  logic         cfg_stb_q;
  adc_channel_t cfg_channel_q;
  thresh_sel_t  cfg_sel_q;
  threshold_t   cfg_value_q;

  // decoded stage, which drives the checkers.
  channel_mask_t chan_sample_stb_q;
  channel_mask_t chan_cfg_stb_q;
  adc_result_t   result_out_q;
  thresh_sel_t   sel_out_q;
  threshold_t    value_out_q;

  // turns a strobe and a channel number into a one-hot channel strobe.
  // Channels outside the checked set give an empty mask.
  function automatic channel_mask_t channel_decode(input logic stb, input adc_channel_t channel);
    channel_mask_t mask;
    mask = '0;
    if (stb && (channel < adc_channel_t'(NUM_CHANNELS))) begin
      mask = channel_mask_t'(1) << channel;
    end
    return mask;
  endfunction

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      sample_stb_q <= 1'b0;
      cfg_stb_q    <= 1'b0;
    end else begin
      sample_stb_q <= sample_stb_i;
      cfg_stb_q    <= cfg_stb_i;
    end
  end

  always_ff @(posedge gclk40) begin
    sample_channel_q <= sample_channel_i;
    sample_result_q  <= sample_result_i;
    cfg_channel_q    <= cfg_channel_i;
    cfg_sel_q        <= cfg_sel_i;
    cfg_value_q      <= cfg_value_i;
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      chan_sample_stb_q <= '0;
      chan_cfg_stb_q    <= '0;
    end else begin
      chan_sample_stb_q <= channel_decode(sample_stb_q, sample_channel_q);
      chan_cfg_stb_q    <= channel_decode(cfg_stb_q, cfg_channel_q);
    end
  end

  // the data is shared by all checkers; only the strobes are per channel.
  always_ff @(posedge gclk40) begin
    result_out_q <= sample_result_q;
    sel_out_q    <= cfg_sel_q;
    value_out_q  <= cfg_value_q;
  end

  assign chan_sample_stb_o = chan_sample_stb_q;
  assign sample_result_o   = result_out_q;
  assign chan_cfg_stb_o    = chan_cfg_stb_q;
  assign cfg_sel_o         = sel_out_q;
  assign cfg_value_o       = value_out_q;

endmodule

/* hw/channel_level_checker.sv */
module channel_level_checker
  import adc_pkg::*, health_pkg::*;
(
  input  logic        gclk40,
  input  logic        hard_reset,
  input  logic        sample_stb_i,
  input  adc_result_t sample_result_i,
  input  logic        cfg_stb_i,
  input  thresh_sel_t cfg_sel_i,
  input  threshold_t  cfg_value_i,
  output logic        flag_stb_o,
  output logic        soft_viol_o,
  output logic        hard_viol_o
);

  // this channel's two upper limits.
  threshold_t soft_thr_q;
  threshold_t hard_thr_q;

  logic flag_stb_q;
  logic soft_viol_q;
  logic hard_viol_q;

  // comparison results for the sample on the input this cycle.
  logic soft_exceed;
  logic hard_exceed;

  // a result equal to the threshold is still in range.
  assign soft_exceed = sample_result_i > soft_thr_q;
  assign hard_exceed = sample_result_i > hard_thr_q;

  // threshold registers.
  // A write lands at the same edge as a comparison in flight, and that comparison
  // still uses the old value.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      soft_thr_q <= THRESHOLD_RESET;
      hard_thr_q <= THRESHOLD_RESET;
    end else if (cfg_stb_i) begin
      if (cfg_sel_i == SEL_HARD) begin
        hard_thr_q <= cfg_value_i;
      end else begin
        soft_thr_q <= cfg_value_i;
      end
    end
  end

  // the flag strobe is a single-cycle pulse per checked sample.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      flag_stb_q <= 1'b0;
    end else begin
      flag_stb_q <= sample_stb_i;
    end
  end

  // violation flags keep the result of the last sample on this channel.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      soft_viol_q <= 1'b0;
      hard_viol_q <= 1'b0;
    end else if (sample_stb_i) begin
      soft_viol_q <= soft_exceed;
      hard_viol_q <= hard_exceed;
    end
  end

  assign flag_stb_o  = flag_stb_q;
  assign soft_viol_o = soft_viol_q;
  assign hard_viol_o = hard_viol_q;

endmodule

/* hw/health_aggregator.sv */
module health_aggregator
  import adc_pkg::*, health_pkg::*;
(
  input  logic          gclk40,
  input  logic          hard_reset,
  input  channel_mask_t flag_stb_i,
  input  channel_mask_t soft_flag_i,
  input  channel_mask_t hard_flag_i,
  input  logic          irq_ack_i,
  input  logic          rearm_i,
  output channel_mask_t in_range_o,
  output channel_mask_t pending_o,
  output logic          irq_o,
  output logic          hard_trip_o,
  output logic          power_ok_o
);

  channel_mask_t in_range_q;
  channel_mask_t pending_q;
  channel_mask_t pending_d;
  logic          irq_q;

  // flags only count in the cycle their channel strobes.
  channel_mask_t soft_hits;
  logic          hard_hit;

  trip_state_t state_q;
  trip_state_t state_d;

  assign soft_hits = flag_stb_i & soft_flag_i;
  assign hard_hit  = |(flag_stb_i & hard_flag_i);

  // each strobed channel takes its new in-range state, the others hold.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      in_range_q <= '1;
    end else begin
      in_range_q <= (in_range_q & ~flag_stb_i) | (flag_stb_i & ~soft_flag_i);
    end
  end

  // the acknowledge clears everything pending, but a soft violation arriving in
  // the same cycle is set again so that it cannot be lost.
  always_comb begin
    pending_d = pending_q;
    if (irq_ack_i) begin
      pending_d = '0;
    end
    pending_d = pending_d | soft_hits;
  end

  // irq follows the next pending state so it lines up with pending_o.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      pending_q <= '0;
      irq_q     <= 1'b0;
    end else begin
      pending_q <= pending_d;
      irq_q     <= |pending_d;
    end
  end

  // trip FSM.
  always_comb begin
    state_d = state_q;
    case (state_q)
      TRIP_RUN: begin
        if (hard_hit) begin
          state_d = TRIP_TRIPPED;
        end
      end
      TRIP_TRIPPED: begin
        // a re-arm is refused while a fresh hard violation is arriving.
        if (rearm_i && !hard_hit) begin
          state_d = TRIP_RUN;
        end
      end
      default: begin
        state_d = TRIP_TRIPPED;
      end
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      state_q <= TRIP_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  assign in_range_o  = in_range_q;
  assign pending_o   = pending_q;
  assign irq_o       = irq_q;
  assign hard_trip_o = (state_q == TRIP_TRIPPED);
  assign power_ok_o  = (state_q == TRIP_RUN);

endmodule

/* hw/health_pkg.sv */
// describes the threshold programming and the power trip state.
package health_pkg;

  // a threshold is compared directly against a conversion result, so it shares the
  // ADC result width.
  typedef logic [adc_pkg::ADC_RESULT_W-1:0] threshold_t;

  // all ones at reset, so no result can exceed a threshold that was never written.
  localparam threshold_t THRESHOLD_RESET = '1;

  // selects which of the two per-channel thresholds a config write updates.
  typedef enum logic {
    SEL_SOFT = 1'b0,
    SEL_HARD = 1'b1
  } thresh_sel_t;

  // power trip FSM.
  // TRIP_RUN keeps power good asserted, TRIP_TRIPPED holds it low until re-armed.
  typedef enum logic {
    TRIP_RUN     = 1'b0,
    TRIP_TRIPPED = 1'b1
  } trip_state_t;

endpackage

/* hw/monitor_top.sv */
module monitor_top
  import adc_pkg::*, health_pkg::*;
(
  input  logic          gclk40,
  input  logic          hard_reset,
  // conversion results from the ADC sequencer
  input  logic          sample_stb_i,
  input  adc_channel_t  sample_channel_i,
  input  adc_result_t   sample_result_i,
  // threshold programming
  input  logic          cfg_stb_i,
  input  adc_channel_t  cfg_channel_i,
  input  thresh_sel_t   cfg_sel_i,
  input  threshold_t    cfg_value_i,
  // interrupt and trip control
  input  logic          irq_ack_i,
  input  logic          rearm_i,
  output channel_mask_t in_range_o,
  output channel_mask_t pending_o,
  output logic          irq_o,
  output logic          hard_trip_o,
  output logic          power_ok_o
);

  // router to checkers.
  channel_mask_t chan_sample_stb;
  adc_result_t   routed_result;
  channel_mask_t chan_cfg_stb;
  thresh_sel_t   routed_sel;
  threshold_t    routed_value;

  // checkers to aggregator, one bit per channel.
  channel_mask_t flag_stb;
  channel_mask_t soft_flag;
  channel_mask_t hard_flag;

  adc_sample_router router_inst (
    .gclk40            (gclk40),
    .hard_reset        (hard_reset),
    .sample_stb_i      (sample_stb_i),
    .sample_channel_i  (sample_channel_i),
    .sample_result_i   (sample_result_i),
    .cfg_stb_i         (cfg_stb_i),
    .cfg_channel_i     (cfg_channel_i),
    .cfg_sel_i         (cfg_sel_i),
    .cfg_value_i       (cfg_value_i),
    .chan_sample_stb_o (chan_sample_stb),
    .sample_result_o   (routed_result),
    .chan_cfg_stb_o    (chan_cfg_stb),
    .cfg_sel_o         (routed_sel),
    .cfg_value_o       (routed_value)
  );

  // one checker per monitored rail.
  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_checker
    channel_level_checker checker_inst (
      .gclk40          (gclk40),
      .hard_reset      (hard_reset),
      .sample_stb_i    (chan_sample_stb[i]),
      .sample_result_i (routed_result),
      .cfg_stb_i       (chan_cfg_stb[i]),
      .cfg_sel_i       (routed_sel),
      .cfg_value_i     (routed_value),
      .flag_stb_o      (flag_stb[i]),
      .soft_viol_o     (soft_flag[i]),
      .hard_viol_o     (hard_flag[i])
    );
  end

  health_aggregator aggregator_inst (
    .gclk40      (gclk40),
    .hard_reset  (hard_reset),
    .flag_stb_i  (flag_stb),
    .soft_flag_i (soft_flag),
    .hard_flag_i (hard_flag),
    .irq_ack_i   (irq_ack_i),
    .rearm_i     (rearm_i),
    .in_range_o  (in_range_o),
    .pending_o   (pending_o),
    .irq_o       (irq_o),
    .hard_trip_o (hard_trip_o),
    .power_ok_o  (power_ok_o)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the voltage monitor testbench with Verilator and runs it.
# The run passes only if the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f compile.f \
  --top-module monitor_tb \
  -Mdir obj_dir -o monitor_sim > build.log 2>&1 &&
./obj_dir/monitor_sim > sim.log 2>&1 ||
{ echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "Everything OK" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

/* verif/monitor_tb_tasks.svh */
// reference copy of every channel's thresholds.
threshold_t m_soft [NUM_CHANNELS];
threshold_t m_hard [NUM_CHANNELS];

logic [31:0] lfsr_state = LFSR_SEED;

// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit.
function automatic logic lfsr_step();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_step()};
  end
  return r;
endfunction

function automatic void reset_thresholds();
  for (int i = 0; i < NUM_CHANNELS; i++) begin
    m_soft[i] = THRESHOLD_RESET;
    m_hard[i] = THRESHOLD_RESET;
  end
endfunction

// writes to channels outside the checked set are dropped.
function automatic void model_write(input adc_channel_t ch, input thresh_sel_t sel,
                                    input threshold_t val);
  if (ch < adc_channel_t'(NUM_CHANNELS)) begin
    if (sel == SEL_HARD) begin
      m_hard[ch[2:0]] = val;
    end else begin
      m_soft[ch[2:0]] = val;
    end
  end
endfunction

task automatic send_sample(input adc_channel_t ch, input adc_result_t res);
  @(negedge gclk40);
  sample_stb_i     = 1'b1;
  sample_channel_i = ch;
  sample_result_i  = res;
  @(negedge gclk40);
  sample_stb_i = 1'b0;
endtask

task automatic write_threshold(input adc_channel_t ch, input thresh_sel_t sel,
                               input threshold_t val);
  @(negedge gclk40);
  cfg_stb_i     = 1'b1;
  cfg_channel_i = ch;
  cfg_sel_i     = sel;
  cfg_value_i   = val;
  @(negedge gclk40);
  cfg_stb_i = 1'b0;
endtask

task automatic pulse_ack();
  @(negedge gclk40);
  irq_ack_i = 1'b1;
  @(negedge gclk40);
  irq_ack_i = 1'b0;
endtask

task automatic pulse_rearm();
  @(negedge gclk40);
  rearm_i = 1'b1;
  @(negedge gclk40);
  rearm_i = 1'b0;
endtask

// the sample path has a fixed latency of three edges.
task automatic settle();
  repeat (3) @(negedge gclk40);
endtask

task automatic wait_irq(input logic level);
  int n;
  n = 0;
  while (irq_o !== level && n < IRQ_TIMEOUT) begin
    @(negedge gclk40);
    n++;
  end
  if (irq_o !== level) begin
    $display("timeout: irq_o never reached %0b", level);
    err_count++;
    timed_out = 1'b1;
  end
endtask

task automatic wait_trip(input logic level);
  int n;
  n = 0;
  while (hard_trip_o !== level && n < TRIP_TIMEOUT) begin
    @(negedge gclk40);
    n++;
  end
  if (hard_trip_o !== level) begin
    $display("timeout: hard_trip_o never reached %0b", level);
    err_count++;
    timed_out = 1'b1;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("Mismatch at %0t: %s got %0b expected %0b", $time, name, got, exp);
    err_count++;
  end
endtask

/* verif/monitor_tb.sv */
module monitor_tb
  import adc_pkg::*, health_pkg::*;
();

  localparam logic [31:0] LFSR_SEED = 32'h6ce7ce01;
  localparam int IRQ_TIMEOUT = 20;
  localparam int TRIP_TIMEOUT = 20;
  localparam int NUM_TESTS = 6;

  logic          gclk40 = 1'b0;
  logic          hard_reset;
  logic          sample_stb_i;
  adc_channel_t  sample_channel_i;
  adc_result_t   sample_result_i;
  logic          cfg_stb_i;
  adc_channel_t  cfg_channel_i;
  thresh_sel_t   cfg_sel_i;
  threshold_t    cfg_value_i;
  logic          irq_ack_i;
  logic          rearm_i;
  channel_mask_t in_range_o;
  channel_mask_t pending_o;
  logic          irq_o;
  logic          hard_trip_o;
  logic          power_ok_o;

  int err_count = 0;
  int test_base = 0;
  int tests_run = 0;
  logic timed_out = 1'b0;

  // expected outputs and the in-flight samples and writes behind them.
  channel_mask_t m_in_range;
  channel_mask_t m_pending;
  logic          m_irq;
  logic          m_trip;
  logic          d_stb [3];
  logic [2:0]    d_ch [3];
  adc_result_t   d_res [3];
  logic          d_soft [3];
  logic          d_hard [3];
  logic          c_stb [2];
  adc_channel_t  c_ch [2];
  thresh_sel_t   c_sel [2];
  threshold_t    c_val [2];

  `include "monitor_tb_tasks.svh"

  always #2 gclk40 = ~gclk40;

  monitor_top dut0 (.*);

  // a sample compares two edges after capture and shows three edges after capture;
  // a write lands two edges after capture.
  always @(posedge gclk40) begin
    if (!hard_reset) begin
      m_in_range = '1;
      m_pending = '0;
      m_irq = 1'b0;
      m_trip = 1'b0;
      reset_thresholds();
      for (int i = 0; i < 3; i++) d_stb[i] = 1'b0;
      for (int i = 0; i < 2; i++) c_stb[i] = 1'b0;
    end else begin
      if (d_stb[2]) m_in_range[d_ch[2]] = !d_soft[2];
      if (irq_ack_i) m_pending = '0;
      if (d_stb[2] && d_soft[2]) m_pending[d_ch[2]] = 1'b1;
      m_irq = |m_pending;
      if (d_stb[2] && d_hard[2]) begin
        m_trip = 1'b1;
      end else if (rearm_i) begin
        m_trip = 1'b0;
      end
      d_soft[1] = d_res[1] > m_soft[d_ch[1]];
      d_hard[1] = d_res[1] > m_hard[d_ch[1]];
      if (c_stb[1]) model_write(c_ch[1], c_sel[1], c_val[1]);
      for (int i = 2; i > 0; i--) begin
        d_stb[i] = d_stb[i-1];
        d_ch[i]  = d_ch[i-1];
        d_res[i] = d_res[i-1];
        d_soft[i] = d_soft[i-1];
        d_hard[i] = d_hard[i-1];
      end
      d_stb[0] = sample_stb_i && (sample_channel_i < adc_channel_t'(NUM_CHANNELS));
      d_ch[0]  = sample_channel_i[2:0];
      d_res[0] = sample_result_i;
      c_stb[1] = c_stb[0];
      c_ch[1]  = c_ch[0];
      c_sel[1] = c_sel[0];
      c_val[1] = c_val[0];
      c_stb[0] = cfg_stb_i;
      c_ch[0]  = cfg_channel_i;
      c_sel[0] = cfg_sel_i;
      c_val[0] = cfg_value_i;
    end
  end

  assert property (@(negedge gclk40) in_range_o == m_in_range) else begin
    $display("Mismatch at %0t: in_range_o got %h expected %h", $time, in_range_o, m_in_range);
    err_count++;
  end
  assert property (@(negedge gclk40) pending_o == m_pending) else begin
    $display("Mismatch at %0t: pending_o got %h expected %h", $time, pending_o, m_pending);
    err_count++;
  end
  assert property (@(negedge gclk40) irq_o == m_irq) else begin
    $display("Mismatch at %0t: irq_o got %0b expected %0b", $time, irq_o, m_irq);
    err_count++;
  end
  assert property (@(negedge gclk40) hard_trip_o == m_trip) else begin
    $display("Mismatch at %0t: hard_trip_o got %0b expected %0b", $time, hard_trip_o, m_trip);
    err_count++;
  end
  assert property (@(negedge gclk40) power_ok_o == !m_trip) else begin
    $display("Mismatch at %0t: power_ok_o got %0b expected %0b", $time, power_ok_o, !m_trip);
    err_count++;
  end

  task automatic end_test(input string name);
    $display("test %0d %s finished with %0d errors", tests_run + 1, name, err_count - test_base);
    tests_run++;
    test_base = err_count;
  endtask

  initial begin
    adc_channel_t ch;
    hard_reset = 1'b0;
    sample_stb_i = 1'b0;
    sample_channel_i = '0;
    sample_result_i = '0;
    cfg_stb_i = 1'b0;
    cfg_channel_i = '0;
    cfg_sel_i = SEL_SOFT;
    cfg_value_i = '0;
    irq_ack_i = 1'b0;
    rearm_i = 1'b0;
    repeat (16) @(negedge gclk40);
    hard_reset = 1'b1;

    @(negedge gclk40);
    check_bit("irq_o", irq_o, 1'b0);
    check_bit("power_ok_o", power_ok_o, 1'b1);
    check_bit("in_range_o all ones", &in_range_o, 1'b1);
    for (int i = 0; i < NUM_CHANNELS; i++) send_sample(adc_channel_t'(i), '1);
    settle();
    end_test("reset state");

    for (int i = 0; i < NUM_CHANNELS; i++) begin
      write_threshold(adc_channel_t'(i), SEL_SOFT, threshold_t'(rand_bits(12)));
    end
    for (int i = 0; i < 40; i++) begin
      send_sample(adc_channel_t'(rand_bits(3)), adc_result_t'(rand_bits(12)));
    end
    settle();
    end_test("soft comparison");

    pulse_ack();
    write_threshold(5'd3, SEL_SOFT, 12'h400);
    send_sample(5'd3, 12'h500);
    wait_irq(1'b1);
    send_sample(5'd3, 12'h100);
    settle();
    check_bit("pending_o[3]", pending_o[3], 1'b1);
    pulse_ack();
    wait_irq(1'b0);
    // the acknowledge meets the arriving soft flag.
    send_sample(5'd3, 12'h600);
    @(negedge gclk40);
    pulse_ack();
    check_bit("pending_o[3]", pending_o[3], 1'b1);
    end_test("sticky interrupt");

    if (!timed_out) begin
      write_threshold(5'd5, SEL_HARD, 12'h800);
      send_sample(5'd5, 12'h900);
      wait_trip(1'b1);
      send_sample(5'd5, 12'h100);
      settle();
      check_bit("hard_trip_o", hard_trip_o, 1'b1);
      send_sample(5'd5, 12'h900);
      @(negedge gclk40);
      pulse_rearm();
      check_bit("hard_trip_o", hard_trip_o, 1'b1);
      pulse_rearm();
      wait_trip(1'b0);
      end_test("hard trip");
    end

    if (!timed_out) begin
      for (int i = 0; i < 12; i++) begin
        ch = adc_channel_t'(rand_bits(5));
        if (ch < 5'd8) ch = ch + 5'd8;
        write_threshold(ch, thresh_sel_t'(rand_bits(1)), '0);
        send_sample(ch, '1);
      end
      for (int i = 0; i < 24; i++) begin
        @(negedge gclk40);
        sample_stb_i = 1'b1;
        sample_channel_i = adc_channel_t'(rand_bits(5));
        sample_result_i = adc_result_t'(rand_bits(12));
      end
      @(negedge gclk40);
      sample_stb_i = 1'b0;
      settle();
      end_test("unused channels");

      write_threshold(5'd2, SEL_SOFT, 12'hfff);
      send_sample(5'd2, 12'h201);
      settle();
      write_threshold(5'd2, SEL_SOFT, 12'h200);
      send_sample(5'd2, 12'h201);
      settle();
      check_bit("in_range_o[2]", in_range_o[2], 1'b0);
      end_test("config timing");
    end

    $display("%0d of %0d tests run, %0d errors", tests_run, NUM_TESTS, err_count);
    if (err_count == 0 && tests_run == NUM_TESTS) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
